// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_processor
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the simulator output
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== alu.sv ====
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module alu (
  input  logic [ctrl_pkg::ALU_OP_BITS-1:0]   alu_op,
  input  logic [`CPU_DATA_WIDTH-1:0]         data1,
  input  logic [`CPU_DATA_WIDTH-1:0]         data2,
  input  logic [$clog2(`CPU_DATA_WIDTH)-1:0] shamt,
  output logic [`CPU_DATA_WIDTH-1:0]         alu_result,
  output logic                               zero,
  output logic                               less,
  output logic                               greater
);
  import ctrl_pkg::*;

  // signed compare of the two operands, used by slt and the branch logic
  assign zero    = (data1 == data2);
  assign less    = ($signed(data1) < $signed(data2));
  assign greater = ($signed(data1) > $signed(data2));

  always_comb begin
    case (alu_op)
      alu_add: alu_result = data1 + data2;
      alu_sub: alu_result = data1 - data2;
      alu_and: alu_result = data1 & data2;
      alu_or:  alu_result = data1 | data2;
      alu_slt: alu_result = {{(`CPU_DATA_WIDTH-1){1'b0}}, less};
      // shifts act on rt
      alu_sll: alu_result = data2 << shamt;
      alu_srl: alu_result = data2 >> shamt;
      default: alu_result = '0;
    endcase
  end

endmodule

// ==== control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
  input  isa_pkg::instr_t                  instruction,
  output logic                             reg_dst,
  output logic                             alu_src,
  output logic                             mem_to_reg,
  output logic                             reg_write,
  output logic [ctrl_pkg::ALU_OP_BITS-1:0] alu_op,
  output logic [ctrl_pkg::MEM_OP_BITS-1:0] mem_op,
  output logic [ctrl_pkg::JUMP_BITS-1:0]   jop
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  always_comb begin
    // defaults give a harmless no-op
    reg_dst    = 1'b0;
    alu_src    = 1'b0;
    mem_to_reg = 1'b0;
    reg_write  = 1'b0;
    alu_op     = alu_add;
    mem_op     = mem_none;
    jop        = jmp_none;

    case (instruction.i_view.opcode)
      op_rtype: begin
        reg_dst   = 1'b1;
        reg_write = 1'b1;
        case (instruction.r_view.funct)
          fn_add:  alu_op = alu_add;
          fn_sub:  alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          fn_slt:  alu_op = alu_slt;
          fn_sll:  alu_op = alu_sll;
          fn_srl:  alu_op = alu_srl;
          default: reg_write = 1'b0;
        endcase
      end
      op_addi, op_andi, op_ori: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
        if (instruction.i_view.opcode == op_andi)
          alu_op = alu_and;
        else if (instruction.i_view.opcode == op_ori)
          alu_op = alu_or;
      end
      op_lw: begin
        alu_src    = 1'b1;
        mem_to_reg = 1'b1;
        reg_write  = 1'b1;
        mem_op     = mem_load;
      end
      op_sw: begin
        alu_src = 1'b1;
        mem_op  = mem_store;
      end
      // branches compare rs against rt
      op_beq: begin
        alu_op = alu_sub;
        jop    = jmp_beq;
      end
      op_bne: begin
        alu_op = alu_sub;
        jop    = jmp_bne;
      end
      op_j:    jop = jmp_imm;
      op_jr:   jop = jmp_reg;
      default: jop = jmp_none;
    endcase
  end

endmodule

// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath widths
`define CPU_DATA_WIDTH 32
`define CPU_INST_WIDTH 32
`define CPU_ADDR_WIDTH 8
`define CPU_REG_ADDR_BITS 5

// memory depths in words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

`endif

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

  // alu operations
  localparam int ALU_OP_BITS = 3;
  localparam logic [ALU_OP_BITS-1:0] alu_add = 3'd0;
  localparam logic [ALU_OP_BITS-1:0] alu_sub = 3'd1;
  localparam logic [ALU_OP_BITS-1:0] alu_and = 3'd2;
  localparam logic [ALU_OP_BITS-1:0] alu_or  = 3'd3;
  localparam logic [ALU_OP_BITS-1:0] alu_slt = 3'd4;
  localparam logic [ALU_OP_BITS-1:0] alu_sll = 3'd5;
  localparam logic [ALU_OP_BITS-1:0] alu_srl = 3'd6;

  // data memory access
  localparam int MEM_OP_BITS = 2;
  localparam logic [MEM_OP_BITS-1:0] mem_none  = 2'd0;
  localparam logic [MEM_OP_BITS-1:0] mem_load  = 2'd1;
  localparam logic [MEM_OP_BITS-1:0] mem_store = 2'd2;

  // control transfer kinds, resolved in execute
  localparam int JUMP_BITS = 3;
  localparam logic [JUMP_BITS-1:0] jmp_none = 3'd0;
  localparam logic [JUMP_BITS-1:0] jmp_beq  = 3'd1;
  localparam logic [JUMP_BITS-1:0] jmp_bne  = 3'd2;
  localparam logic [JUMP_BITS-1:0] jmp_imm  = 3'd3;
  localparam logic [JUMP_BITS-1:0] jmp_reg  = 3'd4;

  // alu operand source
  localparam int FORWARD_BITS = 2;
  localparam logic [FORWARD_BITS-1:0] fwd_reg = 2'd0;
  localparam logic [FORWARD_BITS-1:0] fwd_wb  = 2'd1;
  localparam logic [FORWARD_BITS-1:0] fwd_mem = 2'd2;

endpackage

// ==== data_memory.sv ====
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module data_memory (
  input  logic                             clk,
  input  logic [`CPU_ADDR_WIDTH-1:0]       address,
  input  logic [`CPU_DATA_WIDTH-1:0]       write_data,
  input  logic [ctrl_pkg::MEM_OP_BITS-1:0] mem_op,
  output logic [`CPU_DATA_WIDTH-1:0]       read_data
);
  import ctrl_pkg::*;

  logic [`CPU_DATA_WIDTH-1:0] ram [`CPU_DMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (mem_op == mem_store)
      ram[address] <= write_data;
  end

  // word addressed, asynchronous read
  assign read_data = ram[address];

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       stall,
  input  logic                       flush,
  input  logic [`CPU_ADDR_WIDTH-1:0] target,
  input  logic                       imem_write,
  input  logic [`CPU_ADDR_WIDTH-1:0] imem_addr,
  input  logic [`CPU_INST_WIDTH-1:0] imem_data,
  output logic [`CPU_ADDR_WIDTH-1:0] pc,
  output isa_pkg::instr_t            instruction
);

  logic [`CPU_INST_WIDTH-1:0] imem [`CPU_IMEM_DEPTH];

  // redirect beats stall
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      pc <= '0;
    else if (flush)
      pc <= target;
    else if (!stall)
      pc <= pc + 1'b1;
  end

  // program load port
  always_ff @(posedge clk) begin
    if (imem_write)
      imem[imem_addr] <= imem_data;
  end

  assign instruction = imem[pc];

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module hazard_unit (
  input  logic [`CPU_REG_ADDR_BITS-1:0]     id_ex_rs,
  input  logic [`CPU_REG_ADDR_BITS-1:0]     id_ex_rt,
  input  logic [`CPU_REG_ADDR_BITS-1:0]     ex_mem_rd,
  input  logic                              ex_mem_reg_write,
  input  logic [`CPU_REG_ADDR_BITS-1:0]     mem_wb_rd,
  input  logic                              mem_wb_reg_write,
  input  logic [ctrl_pkg::MEM_OP_BITS-1:0]  id_ex_mem_op,
  input  logic [`CPU_REG_ADDR_BITS-1:0]     if_id_rs,
  input  logic [`CPU_REG_ADDR_BITS-1:0]     if_id_rt,
  output logic [ctrl_pkg::FORWARD_BITS-1:0] forward_a,
  output logic [ctrl_pkg::FORWARD_BITS-1:0] forward_b,
  output logic                              stall
);
  import ctrl_pkg::*;

  // the younger result wins when both stages target the same register
  function automatic logic [FORWARD_BITS-1:0] forward_select(
    input logic [`CPU_REG_ADDR_BITS-1:0] src
  );
    if (ex_mem_reg_write && ex_mem_rd != '0 && ex_mem_rd == src)
      return fwd_mem;
    else if (mem_wb_reg_write && mem_wb_rd != '0 && mem_wb_rd == src)
      return fwd_wb;
    return fwd_reg;
  endfunction

  always_comb begin
    forward_a = forward_select(id_ex_rs);
    forward_b = forward_select(id_ex_rt);
  end

  // load data is not ready until memory, so hold the consumer one cycle
  assign stall = (id_ex_mem_op == mem_load) &&
                 ((id_ex_rt == if_id_rs) || (id_ex_rt == if_id_rt));

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

  // one instruction word, read either as register form or immediate form
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r_view;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i_view;
  } instr_t;

  // opcodes
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_jr    = 6'h03;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_andi  = 6'h0c;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  // funct field of op_rtype
  localparam logic [5:0] fn_sll = 6'h00;
  localparam logic [5:0] fn_srl = 6'h02;
  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or  = 6'h25;
  localparam logic [5:0] fn_slt = 6'h2a;

endpackage

// ==== processor.sv ====
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module processor (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          imem_write,
  input  logic [`CPU_ADDR_WIDTH-1:0]    imem_addr,
  input  logic [`CPU_INST_WIDTH-1:0]    imem_data,
  output logic                          wb_write,
  output logic [`CPU_REG_ADDR_BITS-1:0] wb_reg,
  output logic [`CPU_DATA_WIDTH-1:0]    wb_data,
  output logic                          store_write,
  output logic [`CPU_ADDR_WIDTH-1:0]    store_addr,
  output logic [`CPU_DATA_WIDTH-1:0]    store_data
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  localparam int SHAMT_BITS = $clog2(`CPU_DATA_WIDTH);
  localparam int IMM_BITS   = 16;

  // fetch and decode
  instr_t                        if_instr;
  instr_t                        if_id_instr;
  logic                          if_id_valid;
  logic                          stall;
  logic                          flush;
  logic [`CPU_ADDR_WIDTH-1:0]    branch_target;
  logic                          branch_taken;
  logic [`CPU_DATA_WIDTH-1:0]    rf_rs_data;
  logic [`CPU_DATA_WIDTH-1:0]    rf_rt_data;
  logic                          dec_reg_dst, dec_alu_src, dec_mem_to_reg, dec_reg_write;
  logic [ALU_OP_BITS-1:0]        dec_alu_op;
  logic [MEM_OP_BITS-1:0]        dec_mem_op;
  logic [JUMP_BITS-1:0]          dec_jop;

  // id/ex
  logic                          id_ex_valid;
  logic [`CPU_REG_ADDR_BITS-1:0] id_ex_rs, id_ex_rt, id_ex_rd;
  logic [SHAMT_BITS-1:0]         id_ex_shamt;
  logic [IMM_BITS-1:0]           id_ex_imm;
  logic [`CPU_DATA_WIDTH-1:0]    id_ex_rs_data, id_ex_rt_data;
  logic                          id_ex_reg_dst, id_ex_alu_src, id_ex_mem_to_reg, id_ex_reg_write;
  logic [ALU_OP_BITS-1:0]        id_ex_alu_op;
  logic [MEM_OP_BITS-1:0]        id_ex_mem_op;
  logic [JUMP_BITS-1:0]          id_ex_jop;

  // execute
  logic [FORWARD_BITS-1:0]       forward_a, forward_b;
  logic [`CPU_DATA_WIDTH-1:0]    operand_a, operand_b, alu_in_b, alu_result;
  logic                          alu_zero;
  logic [`CPU_REG_ADDR_BITS-1:0] ex_dst;

  // ex/mem and mem/wb
  logic                          ex_mem_valid, ex_mem_reg_write, ex_mem_mem_to_reg;
  logic [`CPU_DATA_WIDTH-1:0]    ex_mem_alu_result, ex_mem_rt_data, mem_read_data;
  logic [`CPU_REG_ADDR_BITS-1:0] ex_mem_dst;
  logic [MEM_OP_BITS-1:0]        ex_mem_mem_op;
  logic                          mem_wb_valid, mem_wb_reg_write, mem_wb_mem_to_reg;
  logic [`CPU_DATA_WIDTH-1:0]    mem_wb_alu_result, mem_wb_read_data, wb_value;
  logic [`CPU_REG_ADDR_BITS-1:0] mem_wb_dst;

  function automatic logic [`CPU_DATA_WIDTH-1:0] forward_mux(
    input logic [FORWARD_BITS-1:0]    sel,
    input logic [`CPU_DATA_WIDTH-1:0] reg_value
  );
    case (sel)
      fwd_mem: return ex_mem_alu_result;
      fwd_wb:  return wb_value;
      default: return reg_value;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // fetch and decode

  fetch_unit u_fetch (
    .clk(clk),
    .rst_n(rst_n),
    .stall(stall),
    .flush(flush),
    .target(branch_target),
    .imem_write(imem_write),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .pc(),
    .instruction(if_instr)
  );

  control_unit u_control (
    .instruction(if_id_instr),
    .reg_dst(dec_reg_dst),
    .alu_src(dec_alu_src),
    .mem_to_reg(dec_mem_to_reg),
    .reg_write(dec_reg_write),
    .alu_op(dec_alu_op),
    .mem_op(dec_mem_op),
    .jop(dec_jop)
  );

  register_file u_regs (
    .clk(clk),
    .rst_n(rst_n),
    .write(wb_write),
    .write_address(mem_wb_dst),
    .write_data(wb_value),
    .read_address_1(if_id_instr.r_view.rs),
    .read_data_1(rf_rs_data),
    .read_address_2(if_id_instr.r_view.rt),
    .read_data_2(rf_rt_data)
  );

  hazard_unit u_hazard (
    .id_ex_rs(id_ex_rs),
    .id_ex_rt(id_ex_rt),
    .ex_mem_rd(ex_mem_dst),
    .ex_mem_reg_write(ex_mem_valid & ex_mem_reg_write),
    .mem_wb_rd(mem_wb_dst),
    .mem_wb_reg_write(mem_wb_valid & mem_wb_reg_write),
    .id_ex_mem_op(id_ex_valid ? id_ex_mem_op : mem_none),
    .if_id_rs(if_id_instr.r_view.rs),
    .if_id_rt(if_id_instr.r_view.rt),
    .forward_a(forward_a),
    .forward_b(forward_b),
    .stall(stall)
  );

  //////////////////////////////////////////////////////////////////////
  // execute

  always_comb begin
    operand_a = forward_mux(forward_a, id_ex_rs_data);
    operand_b = forward_mux(forward_b, id_ex_rt_data);
  end

  // immediates are zero-extended
  assign alu_in_b = id_ex_alu_src ? {{(`CPU_DATA_WIDTH-IMM_BITS){1'b0}}, id_ex_imm} : operand_b;
  assign ex_dst   = id_ex_reg_dst ? id_ex_rd : id_ex_rt;

  alu u_alu (
    .alu_op(id_ex_alu_op),
    .data1(operand_a),
    .data2(alu_in_b),
    .shamt(id_ex_shamt),
    .alu_result(alu_result),
    .zero(alu_zero),
    .less(),
    .greater()
  );

  // branch and jump targets are absolute word addresses
  always_comb begin
    branch_taken  = 1'b0;
    branch_target = id_ex_imm[`CPU_ADDR_WIDTH-1:0];
    case (id_ex_jop)
      jmp_beq: branch_taken = alu_zero;
      jmp_bne: branch_taken = ~alu_zero;
      jmp_imm: branch_taken = 1'b1;
      jmp_reg: begin
        branch_taken  = 1'b1;
        branch_target = operand_a[`CPU_ADDR_WIDTH-1:0];
      end
      default: branch_taken = 1'b0;
    endcase
  end

  assign flush = id_ex_valid & branch_taken;

  //////////////////////////////////////////////////////////////////////
  // memory and write-back

  data_memory u_dmem (
    .clk(clk),
    .address(ex_mem_alu_result[`CPU_ADDR_WIDTH-1:0]),
    .write_data(ex_mem_rt_data),
    .mem_op(ex_mem_valid ? ex_mem_mem_op : mem_none),
    .read_data(mem_read_data)
  );

  assign store_write = ex_mem_valid && (ex_mem_mem_op == mem_store);
  assign store_addr  = ex_mem_alu_result[`CPU_ADDR_WIDTH-1:0];
  assign store_data  = ex_mem_rt_data;

  assign wb_value = mem_wb_mem_to_reg ? mem_wb_read_data : mem_wb_alu_result;
  assign wb_write = mem_wb_valid && mem_wb_reg_write && (mem_wb_dst != '0);
  assign wb_reg   = mem_wb_dst;
  assign wb_data  = wb_value;

  //////////////////////////////////////////////////////////////////////
  // pipeline registers

  // stall leaves a bubble in id/ex, a taken transfer kills if/id and id/ex
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_valid  <= 1'b0;
      id_ex_valid  <= 1'b0;
      ex_mem_valid <= 1'b0;
      mem_wb_valid <= 1'b0;
    end else begin
      if (flush)
        if_id_valid <= 1'b0;
      else if (!stall)
        if_id_valid <= 1'b1;
      id_ex_valid  <= if_id_valid & ~stall & ~flush;
      ex_mem_valid <= id_ex_valid;
      mem_wb_valid <= ex_mem_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall)
      if_id_instr <= if_instr;

    id_ex_rs         <= if_id_instr.r_view.rs;
    id_ex_rt         <= if_id_instr.r_view.rt;
    id_ex_rd         <= if_id_instr.r_view.rd;
    id_ex_shamt      <= if_id_instr.r_view.shamt;
    id_ex_imm        <= if_id_instr.i_view.imm;
    id_ex_rs_data    <= rf_rs_data;
    id_ex_rt_data    <= rf_rt_data;
    id_ex_reg_dst    <= dec_reg_dst;
    id_ex_alu_src    <= dec_alu_src;
    id_ex_mem_to_reg <= dec_mem_to_reg;
    id_ex_reg_write  <= dec_reg_write;
    id_ex_alu_op     <= dec_alu_op;
    id_ex_mem_op     <= dec_mem_op;
    id_ex_jop        <= dec_jop;

    ex_mem_alu_result <= alu_result;
    ex_mem_rt_data    <= operand_b;
    ex_mem_dst        <= ex_dst;
    ex_mem_reg_write  <= id_ex_reg_write;
    ex_mem_mem_to_reg <= id_ex_mem_to_reg;
    ex_mem_mem_op     <= id_ex_mem_op;

    mem_wb_alu_result <= ex_mem_alu_result;
    mem_wb_read_data  <= mem_read_data;
    mem_wb_dst        <= ex_mem_dst;
    mem_wb_reg_write  <= ex_mem_reg_write;
    mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
  end

endmodule

// ==== project.f ====
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
control_unit.sv
register_file.sv
alu.sv
hazard_unit.sv
fetch_unit.sv
data_memory.sv
processor.sv
tb_processor.sv

// ==== register_file.sv ====
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module register_file (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          write,
  input  logic [`CPU_REG_ADDR_BITS-1:0] write_address,
  input  logic [`CPU_DATA_WIDTH-1:0]    write_data,
  input  logic [`CPU_REG_ADDR_BITS-1:0] read_address_1,
  output logic [`CPU_DATA_WIDTH-1:0]    read_data_1,
  input  logic [`CPU_REG_ADDR_BITS-1:0] read_address_2,
  output logic [`CPU_DATA_WIDTH-1:0]    read_data_2
);

  localparam int NUM_REGS = 1 << `CPU_REG_ADDR_BITS;

  logic [`CPU_DATA_WIDTH-1:0] regs [NUM_REGS];
  logic                       hit_1;
  logic                       hit_2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end else if (write && write_address != '0) begin
      regs[write_address] <= write_data;
    end
  end

  // write-back data bypasses the array in the same cycle
  assign hit_1 = write && (write_address == read_address_1);
  assign hit_2 = write && (write_address == read_address_2);

  assign read_data_1 = (read_address_1 == '0) ? '0 :
                       hit_1 ? write_data : regs[read_address_1];
  assign read_data_2 = (read_address_2 == '0) ? '0 :
                       hit_2 ? write_data : regs[read_address_2];

endmodule

// ==== tb_processor.sv ====
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module tb_processor;
  import isa_pkg::*;

  // six short programs each take well under 150 cycles with reset and load included
  localparam int MAX_CYCLES = 3000;
  // a wrongly retired instruction reports within pipeline depth plus branch penalty
  localparam int SETTLE_CYCLES = 8;

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic                          imem_write;
  logic [`CPU_ADDR_WIDTH-1:0]    imem_addr;
  logic [`CPU_INST_WIDTH-1:0]    imem_data;
  logic                          wb_write;
  logic [`CPU_REG_ADDR_BITS-1:0] wb_reg;
  logic [`CPU_DATA_WIDTH-1:0]    wb_data;
  logic                          store_write;
  logic [`CPU_ADDR_WIDTH-1:0]    store_addr;
  logic [`CPU_DATA_WIDTH-1:0]    store_data;

  logic [31:0] prog [$];
  logic [31:0] exp_wb_reg [$];
  logic [31:0] exp_wb_data [$];
  logic [31:0] exp_st_addr [$];
  logic [31:0] exp_st_data [$];
  logic [31:0] ref_mem [`CPU_DMEM_DEPTH];
  logic [31:0] lfsr = 32'h82b7;
  string       test_name = "reset";
  bit          collecting = 1'b0;
  int          wb_idx = 0;
  int          st_idx = 0;
  int          cycles = 0;
  int          value_errors = 0;
  int          other_errors = 0;

  processor dut (
    .clk(clk),
    .rst_n(rst_n),
    .imem_write(imem_write),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .wb_write(wb_write),
    .wb_reg(wb_reg),
    .wb_data(wb_data),
    .store_write(store_write),
    .store_addr(store_addr),
    .store_data(store_data)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles in %s, expected pulses never came", cycles, test_name);
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      $display("Verification failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [31:0] enc_r(input logic [5:0] funct, input int rd, input int rs,
                                        input int rt, input int shamt);
    instr_t w;
    w.r_view.opcode = op_rtype;
    w.r_view.rs     = 5'(rs);
    w.r_view.rt     = 5'(rt);
    w.r_view.rd     = 5'(rd);
    w.r_view.shamt  = 5'(shamt);
    w.r_view.funct  = funct;
    return w;
  endfunction

  // immediate form takes its arguments as opcode rt rs imm
  function automatic logic [31:0] enc_i(input logic [5:0] op, input int rt, input int rs,
                                        input logic [15:0] imm);
    instr_t w;
    w.i_view.opcode = op;
    w.i_view.rs     = 5'(rs);
    w.i_view.rt     = 5'(rt);
    w.i_view.imm    = imm;
    return w;
  endfunction

  task automatic check_word(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      value_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // in-order instruction set rule that runs until the jump-to-self at the end
  task automatic predict_program();
    logic [31:0] regs [32];
    instr_t      ins;
    logic [31:0] a, b, imm, res;
    logic [4:0]  dst;
    int          pc, next_pc, steps;
    bit          done;
    exp_wb_reg.delete();
    exp_wb_data.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    foreach (regs[i])
      regs[i] = '0;
    pc = 0;
    steps = 0;
    done = 1'b0;
    while (!done) begin
      assert (pc < prog.size() && steps < 1000) else begin
        other_errors++;
        $display("%s: reference run left the program at word %0d", test_name, pc);
      end
      if (pc >= prog.size() || steps >= 1000)
        break;
      ins = prog[pc];
      a = regs[ins.r_view.rs];
      b = regs[ins.r_view.rt];
      imm = {16'h0, ins.i_view.imm};
      dst = '0;
      res = '0;
      next_pc = pc + 1;
      case (ins.i_view.opcode)
        op_rtype: begin
          dst = ins.r_view.rd;
          case (ins.r_view.funct)
            fn_add:  res = a + b;
            fn_sub:  res = a - b;
            fn_and:  res = a & b;
            fn_or:   res = a | b;
            fn_slt:  res = {31'b0, $signed(a) < $signed(b)};
            fn_sll:  res = b << ins.r_view.shamt;
            fn_srl:  res = b >> ins.r_view.shamt;
            default: dst = '0;
          endcase
        end
        op_addi, op_andi, op_ori: begin
          dst = ins.i_view.rt;
          res = (ins.i_view.opcode == op_addi) ? a + imm :
                (ins.i_view.opcode == op_andi) ? a & imm : a | imm;
        end
        op_lw: begin
          dst = ins.i_view.rt;
          res = ref_mem[8'(a + imm)];
        end
        op_sw: begin
          ref_mem[8'(a + imm)] = b;
          exp_st_addr.push_back(32'(8'(a + imm)));
          exp_st_data.push_back(b);
        end
        op_beq:  next_pc = (a == b) ? int'(imm[7:0]) : pc + 1;
        op_bne:  next_pc = (a != b) ? int'(imm[7:0]) : pc + 1;
        op_j:    next_pc = int'(imm[7:0]);
        op_jr:   next_pc = int'(a[7:0]);
        default: next_pc = pc + 1;
      endcase
      // register 0 ignores writes and never reports
      if (dst != '0) begin
        regs[dst] = res;
        exp_wb_reg.push_back(32'(dst));
        exp_wb_data.push_back(res);
      end
      done = (ins.i_view.opcode == op_j) && (next_pc == pc);
      pc = next_pc;
      steps++;
    end
  endtask

  always @(posedge clk) begin
    if (collecting && wb_write) begin
      assert (wb_idx < exp_wb_reg.size()) else begin
        other_errors++;
        $display("%s: extra write-back of %h to r%0d", test_name, wb_data, wb_reg);
      end
      if (wb_idx < exp_wb_reg.size()) begin
        check_word($sformatf("wb_reg[%0d]", wb_idx), exp_wb_reg[wb_idx], 32'(wb_reg));
        check_word($sformatf("wb_data[%0d]", wb_idx), exp_wb_data[wb_idx], wb_data);
      end
      wb_idx++;
    end
    if (collecting && store_write) begin
      assert (st_idx < exp_st_addr.size()) else begin
        other_errors++;
        $display("%s: extra store of %h to %h", test_name, store_data, store_addr);
      end
      if (st_idx < exp_st_addr.size()) begin
        check_word($sformatf("store_addr[%0d]", st_idx), exp_st_addr[st_idx], 32'(store_addr));
        check_word($sformatf("store_data[%0d]", st_idx), exp_st_data[st_idx], store_data);
      end
      st_idx++;
    end
  end

  // loads the program under reset and waits for every expected pulse
  task automatic run_program(input string name);
    test_name = name;
    collecting = 1'b0;
    prog.push_back(enc_i(op_j, 0, 0, 16'(prog.size())));
    predict_program();
    rst_n = 1'b0;
    repeat (4) @(negedge clk);
    foreach (prog[i]) begin
      imem_write = 1'b1;
      imem_addr  = 8'(i);
      imem_data  = prog[i];
      @(negedge clk);
    end
    imem_write = 1'b0;
    wb_idx = 0;
    st_idx = 0;
    collecting = 1'b1;
    rst_n = 1'b1;
    while (wb_idx < exp_wb_reg.size() || st_idx < exp_st_addr.size())
      @(negedge clk);
    repeat (SETTLE_CYCLES) @(negedge clk);
    collecting = 1'b0;
    prog.delete();
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic test_alu_ops();
    prog.push_back(enc_i(op_addi, 1, 0, 16'h1234));
    prog.push_back(enc_i(op_ori, 2, 1, 16'h00f0));
    prog.push_back(enc_i(op_andi, 3, 2, 16'h0ff0));
    prog.push_back(enc_r(fn_add, 4, 1, 3, 0));
    prog.push_back(enc_r(fn_sub, 5, 4, 2, 0));
    prog.push_back(enc_r(fn_and, 6, 5, 1, 0));
    prog.push_back(enc_r(fn_or, 7, 6, 4, 0));
    prog.push_back(enc_r(fn_slt, 8, 5, 7, 0));
    prog.push_back(enc_r(fn_sll, 9, 0, 7, 4));
    prog.push_back(enc_r(fn_srl, 10, 0, 9, 3));
    prog.push_back(enc_r(fn_sub, 11, 2, 4, 0));
    prog.push_back(enc_r(fn_slt, 12, 11, 0, 0));
    run_program("alu_ops");
  endtask

  task automatic test_store_load();
    prog.push_back(enc_i(op_addi, 1, 0, 16'h0040));
    prog.push_back(enc_i(op_addi, 2, 0, 16'h5a5a));
    prog.push_back(enc_i(op_sw, 2, 1, 16'h0003));
    prog.push_back(enc_i(op_lw, 3, 1, 16'h0003));
    prog.push_back(enc_r(fn_add, 4, 3, 2, 0));
    prog.push_back(enc_i(op_sw, 4, 1, 16'h0004));
    prog.push_back(enc_i(op_lw, 5, 1, 16'h0004));
    prog.push_back(enc_i(op_sw, 5, 1, 16'h0005));
    prog.push_back(enc_i(op_lw, 6, 1, 16'h0005));
    prog.push_back(enc_r(fn_add, 7, 6, 6, 0));
    run_program("store_load");
  endtask

  // skipped words write r4 r5 r6 while fall-through words write r7 r8
  task automatic test_branches();
    prog.push_back(enc_i(op_addi, 1, 0, 16'd5));
    prog.push_back(enc_i(op_addi, 2, 0, 16'd5));
    prog.push_back(enc_i(op_addi, 3, 0, 16'd7));
    prog.push_back(enc_i(op_beq, 2, 1, 16'd6));
    prog.push_back(enc_i(op_addi, 4, 0, 16'd1));
    prog.push_back(enc_i(op_addi, 5, 0, 16'd2));
    prog.push_back(enc_i(op_bne, 3, 1, 16'd8));
    prog.push_back(enc_i(op_addi, 6, 0, 16'd3));
    prog.push_back(enc_i(op_beq, 3, 1, 16'd10));
    prog.push_back(enc_i(op_addi, 7, 0, 16'd4));
    prog.push_back(enc_i(op_bne, 2, 1, 16'd12));
    prog.push_back(enc_i(op_addi, 8, 0, 16'd5));
    prog.push_back(enc_i(op_addi, 9, 0, 16'd6));
    run_program("branches");
  endtask

  task automatic test_jumps();
    prog.push_back(enc_i(op_addi, 1, 0, 16'h0011));
    prog.push_back(enc_i(op_j, 0, 0, 16'd4));
    prog.push_back(enc_i(op_addi, 2, 0, 16'd1));
    prog.push_back(enc_i(op_addi, 3, 0, 16'd2));
    prog.push_back(enc_i(op_addi, 4, 0, 16'd8));
    prog.push_back(enc_i(op_jr, 0, 4, 16'd0));
    prog.push_back(enc_i(op_addi, 5, 0, 16'd3));
    prog.push_back(enc_i(op_addi, 6, 0, 16'd4));
    prog.push_back(enc_r(fn_add, 7, 1, 4, 0));
    run_program("jumps");
  endtask

  task automatic test_random_chain();
    logic [5:0] functs [7];
    logic [2:0] sel;
    int         rd, rs, rt, sh;
    functs = '{fn_add, fn_sub, fn_and, fn_or, fn_slt, fn_sll, fn_srl};
    for (int r = 1; r < 8; r++)
      prog.push_back(enc_i(op_ori, r, 0, 16'(random_bits(16))));
    // with few registers in play most operands hit a forwarding path
    for (int k = 0; k < 24; k++) begin
      sel = 3'(random_bits(3));
      rd  = int'(random_bits(3)) + 1;
      rs  = int'(random_bits(3));
      rt  = int'(random_bits(3));
      sh  = int'(random_bits(5));
      prog.push_back(enc_r(functs[(sel == 3'd7) ? 3'd0 : sel], rd, rs, rt, sh));
    end
    run_program("random_chain");
  endtask

  task automatic test_reg_zero();
    prog.push_back(enc_i(op_addi, 0, 0, 16'h0077));
    prog.push_back(enc_i(op_addi, 1, 0, 16'h0010));
    prog.push_back(enc_r(fn_or, 0, 1, 1, 0));
    prog.push_back(enc_r(fn_add, 2, 0, 1, 0));
    prog.push_back(enc_i(op_sw, 0, 1, 16'h0020));
    prog.push_back(enc_i(op_sw, 1, 1, 16'h0021));
    prog.push_back(enc_i(op_lw, 0, 1, 16'h0021));
    prog.push_back(enc_r(fn_add, 3, 0, 1, 0));
    run_program("reg_zero");
  endtask

  initial begin
    rst_n      = 1'b0;
    imem_write = 1'b0;
    imem_addr  = '0;
    imem_data  = '0;
    @(negedge clk);
    test_alu_ops();
    test_store_load();
    test_branches();
    test_jumps();
    test_random_chain();
    test_reg_zero();
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule
